// File: jtag_debug_trace.txt
# name kind bits shift_in expected_out mask expected_dbg_ctrl
# all values hex, shift data LSB first on the wire, DR = data[35:4] addr[3:1] we[0]
idcode_rst    DR    32 000000000 012345A5B 0FFFFFFFF 00000000
ir_capture    IR     4 F         5         F         00000000
bypass_scan   DR    16 C3A5      874A      FFFF      00000000
ir_debug      IR     4 8         5         F         00000000
wr_ctrl       DR    36 DEADBEEF1 000000000 FFFFFFFFF DEADBEEF
rd_ctrl       DR    36 000000000 DEADBEEF0 FFFFFFFFF DEADBEEF
wr_r1         DR    36 111111113 DEADBEEF0 FFFFFFFFF DEADBEEF
wr_r2         DR    36 222222225 111111110 FFFFFFFFF DEADBEEF
wr_r3         DR    36 333333337 222222220 FFFFFFFFF DEADBEEF
wr_r4         DR    36 444444449 333333330 FFFFFFFFF DEADBEEF
wr_r5         DR    36 A5A5A5A5B 444444440 FFFFFFFFF DEADBEEF
wr_r6         DR    36 0F0F0F0FD A5A5A5A50 FFFFFFFFF DEADBEEF
rd_r1         DR    36 000000002 0F0F0F0F0 FFFFFFFFF DEADBEEF
rd_r7         DR    36 00000000E 111111110 FFFFFFFFF DEADBEEF
wr_r7         DR    36 FFFFFFFFF 000000070 FFFFFFFFF DEADBEEF
rd_r7_again   DR    36 00000000E 000000070 FFFFFFFFF DEADBEEF
rd_r5         DR    36 00000000A 000000070 FFFFFFFFF DEADBEEF
rd_r2         DR    36 000000004 A5A5A5A50 FFFFFFFFF DEADBEEF
reset_mid     RESET  2 3         0         0         DEADBEEF
idcode_again  DR    32 000000000 012345A5B 0FFFFFFFF DEADBEEF

// File: project.f
jtag_dbg_pkg.sv
jtag_tap.sv
dbg_dr_chain.sv
dbg_reg_bank.sv
jtag_debug_top.sv
tb_jtag_debug_assertions.sv
tb_jtag_debug.sv

// File: tb_jtag_debug.sv
// JTAG debug port testbench

`timescale 1ns/1ps
`default_nettype none

module tb_jtag_debug
  import jtag_dbg_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // Setup
  ////////////////////////////////////////////////////////////

  localparam ir_t         DEBUG_CMD     = 4'h8;
  localparam logic [31:0] IDCODE_VALUE  = 32'h1234_5A5B;
  localparam int          CLK_PERIOD    = 20;
  // Budget per trace entry, walk + 36 shifts + idles fit well inside
  localparam int          CYCLES_PER_OP = 80;

  logic                      tck;
  logic                      rst_n;
  logic                      tms;
  logic                      tdi;
  logic                      tdo;
  logic [dbg_data_width-1:0] dbg_ctrl;

  // Trace contents, one entry per scan
  string       op_name [$];
  string       op_kind [$];
  int          op_bits [$];
  logic [63:0] op_din  [$];
  logic [63:0] op_dout [$];
  logic [63:0] op_mask [$];
  logic [31:0] op_ctrl [$];

  int n_ops;
  bit trace_loaded;
  int load_errors;
  int mismatches;
  int tests_passed;
  int tests_failed;
  int assert_fails;

  jtag_debug_top #(
    .DEBUG_CMD    (DEBUG_CMD),
    .IDCODE_VALUE (IDCODE_VALUE)
  ) jtag_debug_top_inst (
    .tck      (tck),
    .rst_n    (rst_n),
    .tms      (tms),
    .tdi      (tdi),
    .tdo      (tdo),
    .dbg_ctrl (dbg_ctrl)
  );

  always #(CLK_PERIOD / 2) tck = ~tck;

  ////////////////////////////////////////////////////////////
  // JTAG pin helpers
  ////////////////////////////////////////////////////////////

  // One tck cycle
  // TMS/TDI set here are consumed at the next rising edge, TDO read mid-cycle
  task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
    @(posedge tck);
    tms <= tms_v;
    tdi <= tdi_v;
    @(negedge tck);
    tdo_v = tdo;
  endtask

  // Run-Test/Idle to Shift-IR or Shift-DR
  task automatic goto_shift(input bit to_ir);
    logic unused;
    tck_step(1'b1, 1'b0, unused);
    if (to_ir) begin
      tck_step(1'b1, 1'b0, unused);
    end
    // Select to Capture, then Capture to Shift
    tck_step(1'b0, 1'b0, unused);
    tck_step(1'b0, 1'b0, unused);
  endtask

  // LSB first, TMS rises with the last bit, then Exit1 -> Update -> Idle
  task automatic shift_and_exit(input int nbits, input logic [63:0] din,
                                output logic [63:0] dout);
    logic bit_out;
    dout = '0;
    for (int j = 0; j < nbits; j++) begin
      tck_step(j == nbits - 1, din[j], bit_out);
      dout[j] = bit_out;
    end
    tck_step(1'b1, 1'b0, bit_out);
    tck_step(1'b0, 1'b0, bit_out);
  endtask

  // Abort a Shift-IR with five TMS-high cycles, then settle in Idle
  task automatic reset_mid_shift(input int nbits, input logic [63:0] din);
    logic bit_out;
    goto_shift(1'b1);
    for (int j = 0; j < nbits; j++) begin
      tck_step(1'b0, din[j], bit_out);
    end
    repeat (5) tck_step(1'b1, 1'b0, bit_out);
    tck_step(1'b0, 1'b0, bit_out);
  endtask

  ////////////////////////////////////////////////////////////
  // Trace handling
  ////////////////////////////////////////////////////////////

  task automatic load_trace();
    int          fd;
    int          fields;
    string       line;
    string       name;
    string       kind;
    int          nbits;
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] mask;
    logic [31:0] ctrl;
    fd = $fopen("jtag_debug_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open jtag_debug_trace.txt");
      load_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and empty lines
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%s %s %d %h %h %h %h", name, kind, nbits, din, dout, mask, ctrl);
      if (fields == 7) begin
        op_name.push_back(name);
        op_kind.push_back(kind);
        op_bits.push_back(nbits);
        op_din.push_back(din);
        op_dout.push_back(dout);
        op_mask.push_back(mask);
        op_ctrl.push_back(ctrl);
      end else begin
        $display("Trace line could not be parsed: %s", line);
        load_errors++;
      end
    end
    $fclose(fd);
    n_ops = op_name.size();
  endtask

  task automatic run_entry(input int idx);
    logic [63:0] got;
    logic        unused;
    int          idle;
    bit          ok;
    ok  = 1'b1;
    got = '0;
    if (op_kind[idx] == "IR") begin
      goto_shift(1'b1);
      shift_and_exit(op_bits[idx], op_din[idx], got);
    end else if (op_kind[idx] == "DR") begin
      goto_shift(1'b0);
      shift_and_exit(op_bits[idx], op_din[idx], got);
    end else if (op_kind[idx] == "RESET") begin
      reset_mid_shift(op_bits[idx], op_din[idx]);
    end else begin
      $display("Test %s has an unknown operation kind %s", op_name[idx], op_kind[idx]);
      ok = 1'b0;
    end
    // Edge leaving Update lands here, then 0..3 extra idle cycles
    tck_step(1'b0, 1'b0, unused);
    idle = $urandom_range(3, 0);
    repeat (idle) tck_step(1'b0, 1'b0, unused);
    if (((got ^ op_dout[idx]) & op_mask[idx]) !== 64'd0) begin
      $display("MISMATCH at %0t: %s shifted out %h, expected %h under mask %h",
               $time, op_name[idx], got, op_dout[idx], op_mask[idx]);
      mismatches++;
      ok = 1'b0;
    end
    if (dbg_ctrl !== op_ctrl[idx]) begin
      $display("MISMATCH at %0t: %s dbg_ctrl is %h, expected %h",
               $time, op_name[idx], dbg_ctrl, op_ctrl[idx]);
      mismatches++;
      ok = 1'b0;
    end
    if (ok) begin
      tests_passed++;
      $display("%-14s passed", op_name[idx]);
    end else begin
      tests_failed++;
      $display("%-14s failed", op_name[idx]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    logic unused;
    tck          = 1'b0;
    rst_n        = 1'b0;
    tms          = 1'b1;
    tdi          = 1'b0;
    n_ops        = 0;
    trace_loaded = 1'b0;
    load_errors  = 0;
    mismatches   = 0;
    tests_passed = 0;
    tests_failed = 0;
    assert_fails = 0;
    void'($urandom(49));
    load_trace();
    trace_loaded = 1'b1;
    repeat (2) @(posedge tck);
    rst_n <= 1'b1;
    // Test-Logic-Reset to Run-Test/Idle
    tck_step(1'b0, 1'b0, unused);
    tck_step(1'b0, 1'b0, unused);
    foreach (op_name[i]) begin
      run_entry(i);
    end
    assert_fails = jtag_debug_top_inst.jtag_tap_inst.tap_checks.fail_count +
                   jtag_debug_top_inst.dbg_dr_chain_inst.dr_chain_checks.fail_count;
    $display("%0d tests: %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
             n_ops, tests_passed, tests_failed, mismatches, assert_fails);
    if (tests_failed == 0 && load_errors == 0 && assert_fails == 0 && n_ops > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // One spare slot covers reset and the walk into Idle
  initial begin
    wait (trace_loaded);
    #((n_ops + 1) * CYCLES_PER_OP * CLK_PERIOD);
    $display("Watchdog expired at %0t, the scans did not finish in time", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_jtag_debug_assertions.sv
// TAP and DR chain checks

`timescale 1ns/1ps
`default_nettype none

module tb_jtag_debug_assertions (
  input wire logic tck,
  input wire logic rst_n,
  input wire logic tms,
  input wire logic test_logic_reset,
  input wire logic dbg_sel,
  input wire logic req_valid
);

  // Failure tally, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Five TMS-high edges reach Test-Logic-Reset from any state
  tlr_after_five_tms: assert property (
    @(posedge tck) disable iff (!rst_n) tms [*5] |=> test_logic_reset
  ) else begin
    $error("TAP not in Test-Logic-Reset after five TMS-high cycles");
    fail_count++;
  end

  // Update strobe lasts one cycle
  req_single_cycle: assert property (
    @(posedge tck) disable iff (!rst_n) req_valid |=> !req_valid
  ) else begin
    $error("req_valid held high for two consecutive cycles");
    fail_count++;
  end

  // No request unless the debug instruction is active
  req_needs_sel: assert property (
    @(posedge tck) disable iff (!rst_n) req_valid |-> dbg_sel
  ) else begin
    $error("req_valid raised while dbg_sel is low");
    fail_count++;
  end

endmodule

// TAP side, no request strobe here
bind jtag_tap tb_jtag_debug_assertions tap_checks (
  .tck              (tck),
  .rst_n            (rst_n),
  .tms              (tms),
  .test_logic_reset (test_logic_reset),
  .dbg_sel          (dbg_sel),
  .req_valid        (1'b0)
);

// DR chain side, TMS not visible so the reset check stays idle
bind dbg_dr_chain tb_jtag_debug_assertions dr_chain_checks (
  .tck              (tck),
  .rst_n            (rst_n),
  .tms              (1'b0),
  .test_logic_reset (1'b1),
  .dbg_sel          (dbg_sel),
  .req_valid        (req_valid)
);

`default_nettype wire

// File: jtag_debug_top.sv
// JTAG debug access port

`timescale 1ns/1ps
`default_nettype none

module jtag_debug_top
  import jtag_dbg_pkg::*;
#(
  parameter ir_t         DEBUG_CMD    = 4'h8,
  parameter logic [31:0] IDCODE_VALUE = 32'h1234_5A5B
) (
  input  wire logic                 tck,
  input  wire logic                 rst_n,
  input  wire logic                 tms,
  input  wire logic                 tdi,
  output logic                      tdo,
  output logic [dbg_data_width-1:0] dbg_ctrl
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  // TAP to DR chain
  logic                      dbg_sel;
  logic                      capture_dr;
  logic                      shift_dr;
  logic                      update_dr;
  logic                      dbg_tdo;

  // DR chain to register bank
  logic                      req_valid;
  logic                      req_we;
  logic [dbg_addr_width-1:0] req_addr;
  logic [dbg_data_width-1:0] req_wdata;
  logic [dbg_addr_width-1:0] rd_addr;
  logic [dbg_data_width-1:0] rd_data;

  ////////////////////////////////////////////////////////////
  // TAP controller
  ////////////////////////////////////////////////////////////

  jtag_tap #(
    .DEBUG_CMD    (DEBUG_CMD),
    .IDCODE_VALUE (IDCODE_VALUE)
  ) jtag_tap_inst (
    .tck              (tck),
    .rst_n            (rst_n),
    .tms              (tms),
    .tdi              (tdi),
    .tdo              (tdo),
    .dbg_sel          (dbg_sel),
    .dbg_tdo          (dbg_tdo),
    // TLR flag has no user at this level
    .test_logic_reset (),
    .capture_dr       (capture_dr),
    .shift_dr         (shift_dr),
    .update_dr        (update_dr)
  );

  ////////////////////////////////////////////////////////////
  // Debug DR chain and register bank
  ////////////////////////////////////////////////////////////

  dbg_dr_chain dbg_dr_chain_inst (
    .tck        (tck),
    .rst_n      (rst_n),
    .dbg_sel    (dbg_sel),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .update_dr  (update_dr),
    .tdi        (tdi),
    .dbg_tdo    (dbg_tdo),
    .req_valid  (req_valid),
    .req_we     (req_we),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  dbg_reg_bank dbg_reg_bank_inst (
    .tck       (tck),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_we    (req_we),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .dbg_ctrl  (dbg_ctrl)
  );

endmodule

`default_nettype wire

// File: dbg_reg_bank.sv
// Debug register bank

`timescale 1ns/1ps
`default_nettype none

module dbg_reg_bank
  import jtag_dbg_pkg::*;
(
  input  wire logic                      tck,
  input  wire logic                      rst_n,

  // Single-cycle request from the DR chain
  input  wire logic                      req_valid,
  input  wire logic                      req_we,
  input  wire logic [dbg_addr_width-1:0] req_addr,
  input  wire logic [dbg_data_width-1:0] req_wdata,

  // Combinational read port
  input  wire logic [dbg_addr_width-1:0] rd_addr,
  output logic [dbg_data_width-1:0]      rd_data,

  // Register 0 as a control output
  output logic [dbg_data_width-1:0]      dbg_ctrl
);

  ////////////////////////////////////////////////////////////
  // Variables
  ////////////////////////////////////////////////////////////

  // Writable slots 0..6
  logic [dbg_data_width-1:0] regs [dbg_status_addr];
  // Slot 7, count of accepted writes
  logic [dbg_data_width-1:0] wr_count;
  logic                      wr_accept;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Status slot is read only, writes to it are dropped
  assign wr_accept = req_valid & req_we & (req_addr != dbg_status_addr);

  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < dbg_status_addr; i++) begin
        regs[i] <= '0;
      end
      wr_count <= '0;
    end else if (wr_accept) begin
      regs[req_addr] <= req_wdata;
      wr_count       <= wr_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (rd_addr == dbg_status_addr) begin
      rd_data = wr_count;
    end else begin
      rd_data = regs[rd_addr];
    end
  end

  // Follows a write to slot 0 at the same edge
  assign dbg_ctrl = regs[0];

endmodule

`default_nettype wire

// File: dbg_dr_chain.sv
// Debug data register chain

`timescale 1ns/1ps
`default_nettype none

module dbg_dr_chain
  import jtag_dbg_pkg::*;
(
  input  wire logic                      tck,
  input  wire logic                      rst_n,

  // From the TAP
  input  wire logic                      dbg_sel,
  input  wire logic                      capture_dr,
  input  wire logic                      shift_dr,
  input  wire logic                      update_dr,
  input  wire logic                      tdi,

  // Serial data back to the TAP
  output logic                           dbg_tdo,

  // Request to the register bank, one strobe per update
  output logic                           req_valid,
  output logic                           req_we,
  output logic [dbg_addr_width-1:0]      req_addr,
  output logic [dbg_data_width-1:0]      req_wdata,

  // Read port of the register bank
  output logic [dbg_addr_width-1:0]      rd_addr,
  input  wire logic [dbg_data_width-1:0] rd_data
);

  ////////////////////////////////////////////////////////////
  // Variables
  ////////////////////////////////////////////////////////////

  // Layout, LSB first
  //   [0]     write flag
  //   [3:1]   register address
  //   [35:4]  write data, or read data after capture
  logic [dbg_dr_width-1:0] dr_sr;

  ////////////////////////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////////////////////////

  // Only moves while the debug instruction is active
  always_ff @(posedge tck) begin
    if (dbg_sel) begin
      if (capture_dr) begin
        // Read data lands in the data field, control bits cleared
        dr_sr <= {rd_data, {dbg_data_lsb{1'b0}}};
      end else if (shift_dr) begin
        dr_sr <= {tdi, dr_sr[dbg_dr_width-1:1]};
      end
    end
  end

  // LSB is presented to TDO ahead of each rising edge
  assign dbg_tdo = dr_sr[0];

  ////////////////////////////////////////////////////////////
  // Update request
  ////////////////////////////////////////////////////////////

  // High during Update-DR only
  // Bank acts on the edge that leaves that state
  assign req_valid = update_dr & dbg_sel;

  // Fields straight from the shift register
  assign req_we    = dr_sr[dbg_we_bit];
  assign req_addr  = dr_sr[dbg_addr_lsb +: dbg_addr_width];
  assign req_wdata = dr_sr[dbg_data_lsb +: dbg_data_width];

  ////////////////////////////////////////////////////////////
  // Read address
  ////////////////////////////////////////////////////////////

  // Every update, read or write, retargets the next capture
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (req_valid) begin
      rd_addr <= req_addr;
    end
  end

endmodule

`default_nettype wire

// File: jtag_tap.sv
// IEEE 1149.1 TAP controller

`timescale 1ns/1ps
`default_nettype none

module jtag_tap
  import jtag_dbg_pkg::*;
#(
  parameter ir_t         DEBUG_CMD    = 4'h8,
  parameter logic [31:0] IDCODE_VALUE = 32'h1234_5A5B
) (
  input  wire logic tck,
  input  wire logic rst_n,

  // Serial JTAG pins
  input  wire logic tms,
  input  wire logic tdi,
  output logic      tdo,

  // Debug chain link
  output logic      dbg_sel,
  input  wire logic dbg_tdo,

  // TAP state flags for the debug chain
  output logic      test_logic_reset,
  output logic      capture_dr,
  output logic      shift_dr,
  output logic      update_dr
);

  ////////////////////////////////////////////////////////////
  // Variables
  ////////////////////////////////////////////////////////////

  tap_state_t  state;
  tap_state_t  next_state;

  // IR shift stage and the active instruction
  ir_t         ir_sr;
  ir_t         ir;

  // IDCODE shift register and bypass bit
  logic [31:0] idcode_sr;
  logic        bypass_reg;

  // Serial output of the currently selected DR
  logic        dr_tdo;

  ////////////////////////////////////////////////////////////
  // TAP state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_tlr;
    end else begin
      state <= next_state;
    end
  end

  // Standard 16-state walk, one step per rising tck
  always_comb begin
    next_state = state;
    case (state)
      st_tlr:      next_state = tms ? st_tlr      : st_rti;
      st_rti:      next_state = tms ? st_sel_dr   : st_rti;
      st_sel_dr:   next_state = tms ? st_sel_ir   : st_cap_dr;
      st_cap_dr:   next_state = tms ? st_exit1_dr : st_shift_dr;
      st_shift_dr: next_state = tms ? st_exit1_dr : st_shift_dr;
      st_exit1_dr: next_state = tms ? st_upd_dr   : st_pause_dr;
      st_pause_dr: next_state = tms ? st_exit2_dr : st_pause_dr;
      st_exit2_dr: next_state = tms ? st_upd_dr   : st_shift_dr;
      st_upd_dr:   next_state = tms ? st_sel_dr   : st_rti;
      // Select-IR with TMS high falls back to reset
      st_sel_ir:   next_state = tms ? st_tlr      : st_cap_ir;
      st_cap_ir:   next_state = tms ? st_exit1_ir : st_shift_ir;
      st_shift_ir: next_state = tms ? st_exit1_ir : st_shift_ir;
      st_exit1_ir: next_state = tms ? st_upd_ir   : st_pause_ir;
      st_pause_ir: next_state = tms ? st_exit2_ir : st_pause_ir;
      st_exit2_ir: next_state = tms ? st_upd_ir   : st_shift_ir;
      st_upd_ir:   next_state = tms ? st_sel_dr   : st_rti;
      default:     next_state = st_tlr;
    endcase
  end

  // State flags, high for the whole matching state
  assign test_logic_reset = (state == st_tlr);
  assign capture_dr       = (state == st_cap_dr);
  assign shift_dr         = (state == st_shift_dr);
  assign update_dr        = (state == st_upd_dr);

  ////////////////////////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////////////////////////

  // Shift stage, LSB leaves first and TDI enters at the MSB
  always_ff @(posedge tck) begin
    if (state == st_cap_ir) begin
      ir_sr <= ir_capture_val;
    end else if (state == st_shift_ir) begin
      ir_sr <= {tdi, ir_sr[ir_width-1:1]};
    end
  end

  // Active instruction
  // TLR and rst_n both fall back to IDCODE
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      ir <= ir_idcode;
    end else if (state == st_tlr) begin
      ir <= ir_idcode;
    end else if (state == st_upd_ir) begin
      // New instruction takes hold on leaving Update-IR
      ir <= ir_sr;
    end
  end

  assign dbg_sel = (ir == DEBUG_CMD);

  ////////////////////////////////////////////////////////////
  // IDCODE and bypass registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tck) begin
    if (capture_dr && (ir == ir_idcode)) begin
      idcode_sr <= IDCODE_VALUE;
    end else if (shift_dr && (ir == ir_idcode)) begin
      idcode_sr <= {tdi, idcode_sr[31:1]};
    end
  end

  // Bypass captures 0, so a scan comes out one bit late
  always_ff @(posedge tck) begin
    if (capture_dr) begin
      bypass_reg <= 1'b0;
    end else if (shift_dr) begin
      bypass_reg <= tdi;
    end
  end

  ////////////////////////////////////////////////////////////
  // TDO multiplexer
  ////////////////////////////////////////////////////////////

  // DR select
  // anything not IDCODE or the debug command goes through bypass
  always_comb begin
    case (ir)
      ir_idcode: dr_tdo = idcode_sr[0];
      ir_bypass: dr_tdo = bypass_reg;
      default:   dr_tdo = dbg_sel ? dbg_tdo : bypass_reg;
    endcase
  end

  // Combinational from the active shift register
  // Idle value is 0 outside the shift states
  always_comb begin
    tdo = 1'b0;
    if (state == st_shift_ir) begin
      tdo = ir_sr[0];
    end else if (shift_dr) begin
      tdo = dr_tdo;
    end
  end

endmodule

`default_nettype wire

// File: jtag_dbg_pkg.sv
// JTAG debug port definitions

`default_nettype none

package jtag_dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////////////////////////

  localparam int ir_width = 4;

  typedef logic [ir_width-1:0] ir_t;

  // Selects the 32-bit identification register
  localparam ir_t ir_idcode = 4'h2;
  // Single-bit bypass path
  localparam ir_t ir_bypass = 4'hF;
  // Fixed Capture-IR pattern, LSBs 01 as 1149.1 requires
  localparam ir_t ir_capture_val = 4'b0101;

  ////////////////////////////////////////////////////////////
  // Debug data register layout
  ////////////////////////////////////////////////////////////

  localparam int dbg_addr_width = 3;
  localparam int dbg_data_width = 32;

  // Field positions, LSB first on the wire
  localparam int dbg_we_bit   = 0;
  localparam int dbg_addr_lsb = 1;
  localparam int dbg_data_lsb = 4;

  // Write flag + address + data
  localparam int dbg_dr_width = dbg_data_lsb + dbg_data_width;

  // Top slot of the bank holds the write counter, read only
  localparam logic [dbg_addr_width-1:0] dbg_status_addr = 3'd7;

  ////////////////////////////////////////////////////////////
  // TAP states, standard 1149.1 encoding
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    st_exit2_dr = 4'h0, st_exit1_dr = 4'h1, st_shift_dr = 4'h2, st_pause_dr = 4'h3,
    st_sel_ir   = 4'h4, st_upd_dr   = 4'h5, st_cap_dr   = 4'h6, st_sel_dr   = 4'h7,
    st_exit2_ir = 4'h8, st_exit1_ir = 4'h9, st_shift_ir = 4'hA, st_pause_ir = 4'hB,
    st_rti      = 4'hC, st_upd_ir   = 4'hD, st_cap_ir   = 4'hE, st_tlr      = 4'hF
  } tap_state_t;

endpackage

`default_nettype wire
